// ==== bench/dma_bridge_vectors.txt ====
# kind test data keep last size src dst, all hex
# kind 0 h2c_0 in, 1 h2c_1 in, 2 nf_rx in, 3 nf_tx out, 4 c2h_0 out, 5 c2h_1 out
0 1 1111111111111111 ff 1 0008 0000 0000
3 1 1111111111111111 ff 1 0008 0002 0000
1 2 a0a0a0a0a0a0a0a0 ff 0 0010 0000 0000
1 2 a1a1a1a1a1a1a1a1 0f 1 0010 0000 0000
3 2 a0a0a0a0a0a0a0a0 ff 0 0010 0008 0000
3 2 a1a1a1a1a1a1a1a1 0f 1 0010 0008 0000
0 3 b0b0b0b0b0b0b0b0 ff 0 0010 0000 0000
0 3 b1b1b1b1b1b1b1b1 ff 1 0010 0000 0000
1 3 c0c0c0c0c0c0c0c0 ff 0 000c 0000 0000
1 3 c1c1c1c1c1c1c1c1 0f 1 000c 0000 0000
3 3 b0b0b0b0b0b0b0b0 ff 0 0010 0002 0000
3 3 b1b1b1b1b1b1b1b1 ff 1 0010 0002 0000
3 3 c0c0c0c0c0c0c0c0 ff 0 000c 0008 0000
3 3 c1c1c1c1c1c1c1c1 0f 1 000c 0008 0000
2 4 d0d0d0d0d0d0d0d0 ff 0 0010 0001 0002
2 4 d1d1d1d1d1d1d1d1 ff 1 0099 0001 0002
2 4 e0e0e0e0e0e0e0e0 ff 1 0008 0001 0008
2 4 f0f0f0f0f0f0f0f0 ff 0 0010 0001 000a
2 4 f1f1f1f1f1f1f1f1 03 1 0077 0001 000a
4 4 d0d0d0d0d0d0d0d0 ff 0 0010 0001 0001
4 4 d1d1d1d1d1d1d1d1 ff 1 0010 0001 0001
5 4 e0e0e0e0e0e0e0e0 ff 1 0008 0001 0002
4 4 f0f0f0f0f0f0f0f0 ff 0 0010 0001 0001
4 4 f1f1f1f1f1f1f1f1 03 1 0010 0001 0001
5 4 f0f0f0f0f0f0f0f0 ff 0 0010 0001 0002
5 4 f1f1f1f1f1f1f1f1 03 1 0010 0001 0002
2 5 5050505050505050 ff 0 0018 0004 000a
2 5 5151515151515151 ff 0 0018 0004 000a
2 5 5252525252525252 01 1 0018 0004 000a
4 5 5050505050505050 ff 0 0018 0004 0001
4 5 5151515151515151 ff 0 0018 0004 0001
4 5 5252525252525252 01 1 0018 0004 0001
5 5 5050505050505050 ff 0 0018 0004 0002
5 5 5151515151515151 ff 0 0018 0004 0002
5 5 5252525252525252 01 1 0018 0004 0002

// ==== build.f ====
+incdir+logic
logic/dma_bridge_pkg.sv
logic/reset_hold_timer.sv
logic/h2c_grant_fsm.sv
logic/h2c_merge.sv
logic/c2h_router.sv
logic/dma_bridge_top.sv
bench/dma_bridge_checker.sv
bench/tb_dma_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the dma bridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dma_bridge -f build.f

out=$(./obj_dir/Vtb_dma_bridge)
echo "$out"

if grep -q "Simulation finished: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi

// ==== bench/tb_dma_bridge.sv ====
// testbench for the dma bridge with clock, reset, vector reading and falling-edge stimulus
`timescale 1ns/100ps
`default_nettype none

`include "dma_bridge_params.svh"

module tb_dma_bridge
  import dma_bridge_pkg::*;
;

  localparam int WAIT_LIMIT = 200;
  localparam int MAX_VEC    = 64;

  logic       axis_aclk;
  logic       axis_rst;
  qdma_beat_t h2c_0_beat;
  logic       h2c_0_valid;
  logic       h2c_0_ready;
  qdma_beat_t h2c_1_beat;
  logic       h2c_1_valid;
  logic       h2c_1_ready;
  nf_beat_t   nf_tx_beat;
  logic       nf_tx_valid;
  nf_beat_t   nf_rx_beat;
  logic       nf_rx_valid;
  logic       nf_rx_ready;
  qdma_beat_t c2h_0_beat;
  logic       c2h_0_valid;
  logic       c2h_0_ready;
  qdma_beat_t c2h_1_beat;
  logic       c2h_1_valid;
  logic       c2h_1_ready;
  logic       quiet_check;
  logic       ready_check;

  // vector table, one row per line of the data file
  int          vec_cnt;
  logic [7:0]  v_kind[MAX_VEC];
  logic [7:0]  v_test[MAX_VEC];
  logic [63:0] v_data[MAX_VEC];
  logic [7:0]  v_keep[MAX_VEC];
  logic        v_last[MAX_VEC];
  logic [15:0] v_size[MAX_VEC];
  logic [15:0] v_src[MAX_VEC];
  logic [15:0] v_dst[MAX_VEC];

  qdma_beat_t h2c0_q[$];
  qdma_beat_t h2c1_q[$];
  nf_beat_t   rx_q[$];
  logic       timed_out;
  logic       stall_en;
  int         failed_tests;
  int         errs_before;
  string      test_name[1:5];

  dma_bridge_top dut0 (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .h2c_0_beat  (h2c_0_beat),
    .h2c_0_valid (h2c_0_valid),
    .h2c_0_ready (h2c_0_ready),
    .h2c_1_beat  (h2c_1_beat),
    .h2c_1_valid (h2c_1_valid),
    .h2c_1_ready (h2c_1_ready),
    .nf_tx_beat  (nf_tx_beat),
    .nf_tx_valid (nf_tx_valid),
    .nf_rx_beat  (nf_rx_beat),
    .nf_rx_valid (nf_rx_valid),
    .nf_rx_ready (nf_rx_ready),
    .c2h_0_beat  (c2h_0_beat),
    .c2h_0_valid (c2h_0_valid),
    .c2h_0_ready (c2h_0_ready),
    .c2h_1_beat  (c2h_1_beat),
    .c2h_1_valid (c2h_1_valid),
    .c2h_1_ready (c2h_1_ready)
  );

  dma_bridge_checker chk0 (
    .axis_aclk   (axis_aclk),
    .quiet_check (quiet_check),
    .ready_check (ready_check),
    .h2c_0_valid (h2c_0_valid),
    .h2c_0_ready (h2c_0_ready),
    .h2c_1_valid (h2c_1_valid),
    .h2c_1_ready (h2c_1_ready),
    .nf_tx_beat  (nf_tx_beat),
    .nf_tx_valid (nf_tx_valid),
    .nf_rx_ready (nf_rx_ready),
    .c2h_0_beat  (c2h_0_beat),
    .c2h_0_valid (c2h_0_valid),
    .c2h_0_ready (c2h_0_ready),
    .c2h_1_beat  (c2h_1_beat),
    .c2h_1_valid (c2h_1_valid),
    .c2h_1_ready (c2h_1_ready)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #2 axis_aclk = ~axis_aclk;
  end

  task automatic read_vectors(output logic ok);
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/dma_bridge_vectors.txt", "r");
    vec_cnt = 0;
    ok = (fd != 0);
    if (fd == 0) begin
      $display("could not open the vector file bench/dma_bridge_vectors.txt");
      return;
    end
    while (!$feof(fd) && vec_cnt < MAX_VEC) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", v_kind[vec_cnt], v_test[vec_cnt],
                    v_data[vec_cnt], v_keep[vec_cnt], v_last[vec_cnt], v_size[vec_cnt],
                    v_src[vec_cnt], v_dst[vec_cnt]);
        if (n == 8) vec_cnt++;
      end
    end
    $fclose(fd);
  endtask

  // fills the stimulus queues and hands the expected beats to the checker
  task automatic load_test(input int t);
    qdma_beat_t qb;
    nf_beat_t   nb;
    h2c0_q.delete();
    h2c1_q.delete();
    rx_q.delete();
    errs_before = chk0.errors;
    for (int i = 0; i < vec_cnt; i++) begin
      if (int'(v_test[i]) == t) begin
        qb.data = v_data[i];
        qb.keep = v_keep[i];
        qb.last = v_last[i];
        qb.size = v_size[i];
        qb.src  = v_src[i];
        qb.dst  = v_dst[i];
        nb.data = v_data[i];
        nb.keep = v_keep[i];
        nb.last = v_last[i];
        nb.tuser.reserved = 8'h00;
        nb.tuser.size     = v_size[i];
        nb.tuser.src      = v_src[i][7:0];
        nb.tuser.dst      = v_dst[i][7:0];
        case (v_kind[i])
          8'h0: h2c0_q.push_back(qb);
          8'h1: h2c1_q.push_back(qb);
          8'h2: rx_q.push_back(nb);
          8'h3: chk0.expect_nf(nb);
          8'h4: chk0.expect_c2h(0, qb);
          default: chk0.expect_c2h(1, qb);
        endcase
      end
    end
  endtask

  task automatic random_readys();
    logic [31:0] rnd;
    rnd = $urandom;
    c2h_0_ready = rnd[0] | rnd[1];
    c2h_1_ready = rnd[2] | rnd[3];
  endtask

  // entered on a falling edge, holds each beat until it transfers
  task automatic drive_h2c(input int port);
    qdma_beat_t b;
    int         n;
    int         wait_cnt;
    logic       fired;
    n = (port == 0) ? h2c0_q.size() : h2c1_q.size();
    for (int i = 0; i < n; i++) begin
      b = (port == 0) ? h2c0_q[i] : h2c1_q[i];
      if (port == 0) begin
        h2c_0_beat  = b;
        h2c_0_valid = 1'b1;
      end else begin
        h2c_1_beat  = b;
        h2c_1_valid = 1'b1;
      end
      fired = 1'b0;
      wait_cnt = 0;
      while (!fired && wait_cnt < WAIT_LIMIT) begin
        @(posedge axis_aclk);
        fired = (port == 0) ? (h2c_0_valid && h2c_0_ready) : (h2c_1_valid && h2c_1_ready);
        wait_cnt++;
      end
      @(negedge axis_aclk);
      if (!fired) begin
        $display("timeout: beat %0d on h2c_%0d was never accepted", i, port);
        timed_out = 1'b1;
        break;
      end
    end
    if (port == 0) h2c_0_valid = 1'b0;
    else h2c_1_valid = 1'b0;
  endtask

  task automatic drive_nf_rx();
    int   wait_cnt;
    logic fired;
    for (int i = 0; i < rx_q.size(); i++) begin
      nf_rx_beat  = rx_q[i];
      nf_rx_valid = 1'b1;
      fired = 1'b0;
      wait_cnt = 0;
      while (!fired && wait_cnt < WAIT_LIMIT) begin
        @(posedge axis_aclk);
        fired = nf_rx_valid && nf_rx_ready;
        wait_cnt++;
        if (!fired) begin
          @(negedge axis_aclk);
          if (stall_en) random_readys();
        end
      end
      if (!fired) begin
        $display("timeout: beat %0d on nf_rx was never accepted", i);
        timed_out = 1'b1;
        break;
      end
      @(negedge axis_aclk);
      if (stall_en) random_readys();
    end
    nf_rx_valid = 1'b0;
    c2h_0_ready = 1'b1;
    c2h_1_ready = 1'b1;
  endtask

  task automatic wait_drain();
    int wait_cnt;
    wait_cnt = 0;
    while (chk0.pending() != 0 && wait_cnt < WAIT_LIMIT) begin
      @(negedge axis_aclk);
      wait_cnt++;
    end
    if (chk0.pending() != 0) begin
      $display("timeout: %0d expected beats never came out", chk0.pending());
      timed_out = 1'b1;
    end
  endtask

  task automatic exercise_test(input int t);
    stall_en = (t == 5);
    fork
      drive_h2c(0);
      drive_h2c(1);
      drive_nf_rx();
      begin
        @(negedge axis_aclk);
        ready_check = 1'b0;
      end
    join
    if (!timed_out) wait_drain();
    if (chk0.errors != errs_before || timed_out) begin
      failed_tests++;
      $display("test %0d %s: failed", t, test_name[t]);
    end else begin
      $display("test %0d %s: ok", t, test_name[t]);
    end
  endtask

  initial begin
    logic file_ok;
    axis_rst     = 1'b1;
    h2c_0_beat   = '0;
    h2c_0_valid  = 1'b0;
    h2c_1_beat   = '0;
    h2c_1_valid  = 1'b0;
    // a beat for both card-to-host queues waits while reset holds them idle
    nf_rx_beat   = '0;
    nf_rx_beat.tuser.dst = 8'h0a;
    nf_rx_valid  = 1'b1;
    c2h_0_ready  = 1'b1;
    c2h_1_ready  = 1'b1;
    quiet_check  = 1'b1;
    ready_check  = 1'b0;
    timed_out    = 1'b0;
    stall_en     = 1'b0;
    failed_tests = 0;
    errs_before  = 0;
    void'($urandom(32'h7e8dac0d));
    test_name[1] = "reset hold";
    test_name[2] = "single-queue merge";
    test_name[3] = "contention";
    test_name[4] = "routing";
    test_name[5] = "back-pressure";
    read_vectors(file_ok);
    repeat (16) @(negedge axis_aclk);
    if (file_ok) begin
      // queue 0 already offers a beat while the datapath is held in reset
      load_test(1);
      h2c_0_beat  = h2c0_q[0];
      h2c_0_valid = 1'b1;
      axis_rst    = 1'b0;
      repeat (`RST_HOLD_CYCLES + 1) @(negedge axis_aclk);
      nf_rx_valid = 1'b0;
      quiet_check = 1'b0;
      ready_check = 1'b1;
      exercise_test(1);
      for (int t = 2; t <= 5; t++) begin
        if (!timed_out) begin
          load_test(t);
          exercise_test(t);
        end
      end
    end
    $display("tests failed %0d, checks %0d, errors %0d", failed_tests, chk0.checks,
             chk0.errors);
    if (file_ok && !timed_out && failed_tests == 0 && chk0.errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/dma_bridge_checker.sv ====
// checker that watches the dma bridge ports and compares beats with expected queues
`timescale 1ns/100ps
`default_nettype none

module dma_bridge_checker
  import dma_bridge_pkg::*;
(
  input wire logic       axis_aclk,
  input wire logic       quiet_check,
  input wire logic       ready_check,
  input wire logic       h2c_0_valid,
  input wire logic       h2c_0_ready,
  input wire logic       h2c_1_valid,
  input wire logic       h2c_1_ready,
  input wire nf_beat_t   nf_tx_beat,
  input wire logic       nf_tx_valid,
  input wire logic       nf_rx_ready,
  input wire qdma_beat_t c2h_0_beat,
  input wire logic       c2h_0_valid,
  input wire logic       c2h_0_ready,
  input wire qdma_beat_t c2h_1_beat,
  input wire logic       c2h_1_valid,
  input wire logic       c2h_1_ready
);

  nf_beat_t   nf_exp_q[$];
  qdma_beat_t c2h_0_exp_q[$];
  qdma_beat_t c2h_1_exp_q[$];
  int         checks = 0;
  int         errors = 0;
  logic       h2c_fire_d = 1'b0;

  task automatic expect_nf(input nf_beat_t b);
    nf_exp_q.push_back(b);
  endtask

  task automatic expect_c2h(input int port, input qdma_beat_t b);
    if (port == 0) begin
      c2h_0_exp_q.push_back(b);
    end else begin
      c2h_1_exp_q.push_back(b);
    end
  endtask

  function automatic int pending();
    return nf_exp_q.size() + c2h_0_exp_q.size() + c2h_1_exp_q.size();
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_c2h(input int port, input qdma_beat_t got, input qdma_beat_t exp);
    string p;
    p = (port == 0) ? "c2h_0_beat" : "c2h_1_beat";
    check_field({p, ".data"}, got.data, exp.data);
    check_field({p, ".keep"}, 64'(got.keep), 64'(exp.keep));
    check_field({p, ".last"}, 64'(got.last), 64'(exp.last));
    check_field({p, ".size"}, 64'(got.size), 64'(exp.size));
    check_field({p, ".src"}, 64'(got.src), 64'(exp.src));
    check_field({p, ".dst"}, 64'(got.dst), 64'(exp.dst));
  endtask

  // all outputs that reset must hold low
  always @(posedge axis_aclk) begin
    if (quiet_check) begin
      check_field("h2c_0_ready", 64'(h2c_0_ready), 64'h0);
      check_field("h2c_1_ready", 64'(h2c_1_ready), 64'h0);
      check_field("nf_rx_ready", 64'(nf_rx_ready), 64'h0);
      check_field("nf_tx_valid", 64'(nf_tx_valid), 64'h0);
      check_field("c2h_0_valid", 64'(c2h_0_valid), 64'h0);
      check_field("c2h_1_valid", 64'(c2h_1_valid), 64'h0);
    end
    if (ready_check) begin
      check_field("h2c_0_ready", 64'(h2c_0_ready), 64'h1);
    end
    // input may only move when both queues can take it
    if (!c2h_0_ready || !c2h_1_ready) begin
      check_field("nf_rx_ready", 64'(nf_rx_ready), 64'h0);
    end
  end

  // an accepted host-to-card beat comes out on nf_tx in the next cycle
  always @(posedge axis_aclk) begin
    if (!quiet_check) begin
      check_field("nf_tx_valid", 64'(nf_tx_valid), 64'(h2c_fire_d));
    end
    h2c_fire_d <= (h2c_0_valid && h2c_0_ready) || (h2c_1_valid && h2c_1_ready);
  end

  always @(posedge axis_aclk) begin
    if (nf_tx_valid) begin
      if (nf_exp_q.size() == 0) begin
        errors++;
        $display("a beat came out on nf_tx with no expected beat left");
      end else begin
        check_field("nf_tx_beat.data", nf_tx_beat.data, nf_exp_q[0].data);
        check_field("nf_tx_beat.keep", 64'(nf_tx_beat.keep), 64'(nf_exp_q[0].keep));
        check_field("nf_tx_beat.last", 64'(nf_tx_beat.last), 64'(nf_exp_q[0].last));
        check_field("nf_tx_beat.tuser", 64'(nf_tx_beat.tuser), 64'(nf_exp_q[0].tuser));
        void'(nf_exp_q.pop_front());
      end
    end
    if (c2h_0_valid && c2h_0_ready) begin
      if (c2h_0_exp_q.size() == 0) begin
        errors++;
        $display("a beat came out on c2h_0 with no expected beat left");
      end else begin
        compare_c2h(0, c2h_0_beat, c2h_0_exp_q[0]);
        void'(c2h_0_exp_q.pop_front());
      end
    end
    if (c2h_1_valid && c2h_1_ready) begin
      if (c2h_1_exp_q.size() == 0) begin
        errors++;
        $display("a beat came out on c2h_1 with no expected beat left");
      end else begin
        compare_c2h(1, c2h_1_beat, c2h_1_exp_q[0]);
        void'(c2h_1_exp_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_bridge_top.sv ====
// top level joining reset hold, host-to-card merge and card-to-host router
`timescale 1ns/100ps
`default_nettype none

module dma_bridge_top
  import dma_bridge_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       axis_rst,

  // host-to-card queues
  input  qdma_beat_t h2c_0_beat,
  input  logic       h2c_0_valid,
  output logic       h2c_0_ready,
  input  qdma_beat_t h2c_1_beat,
  input  logic       h2c_1_valid,
  output logic       h2c_1_ready,

  // merged stream into the pipeline, valid only
  output nf_beat_t   nf_tx_beat,
  output logic       nf_tx_valid,

  // stream from the pipeline
  input  nf_beat_t   nf_rx_beat,
  input  logic       nf_rx_valid,
  output logic       nf_rx_ready,

  // card-to-host queues
  output qdma_beat_t c2h_0_beat,
  output logic       c2h_0_valid,
  input  logic       c2h_0_ready,
  output qdma_beat_t c2h_1_beat,
  output logic       c2h_1_valid,
  input  logic       c2h_1_ready
);

  logic dp_rst;
  logic h2c_0_fire;
  logic h2c_1_fire;

  assign h2c_0_fire = h2c_0_valid && h2c_0_ready;
  assign h2c_1_fire = h2c_1_valid && h2c_1_ready;

  reset_hold_timer rst_hold0 (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .dp_rst    (dp_rst)
  );

  h2c_grant_fsm grant0 (
    .axis_aclk   (axis_aclk),
    .dp_rst      (dp_rst),
    .h2c_0_valid (h2c_0_valid),
    .h2c_0_last  (h2c_0_beat.last),
    .h2c_1_valid (h2c_1_valid),
    .h2c_1_last  (h2c_1_beat.last),
    .h2c_0_ready (h2c_0_ready),
    .h2c_1_ready (h2c_1_ready)
  );

  h2c_merge merge0 (
    .axis_aclk   (axis_aclk),
    .dp_rst      (dp_rst),
    .h2c_0_beat  (h2c_0_beat),
    .h2c_1_beat  (h2c_1_beat),
    .h2c_0_fire  (h2c_0_fire),
    .h2c_1_fire  (h2c_1_fire),
    .nf_tx_beat  (nf_tx_beat),
    .nf_tx_valid (nf_tx_valid)
  );

  c2h_router router0 (
    .axis_aclk   (axis_aclk),
    .dp_rst      (dp_rst),
    .nf_rx_beat  (nf_rx_beat),
    .nf_rx_valid (nf_rx_valid),
    .nf_rx_ready (nf_rx_ready),
    .c2h_0_beat  (c2h_0_beat),
    .c2h_1_beat  (c2h_1_beat),
    .c2h_0_valid (c2h_0_valid),
    .c2h_1_valid (c2h_1_valid),
    .c2h_0_ready (c2h_0_ready),
    .c2h_1_ready (c2h_1_ready)
  );

endmodule

`default_nettype wire

// ==== logic/c2h_router.sv ====
// router that steers pipeline beats to the card-to-host queues by dst bits
`timescale 1ns/100ps
`default_nettype none

`include "dma_bridge_params.svh"

module c2h_router
  import dma_bridge_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       dp_rst,
  input  nf_beat_t   nf_rx_beat,
  input  logic       nf_rx_valid,
  output logic       nf_rx_ready,
  output qdma_beat_t c2h_0_beat,
  output qdma_beat_t c2h_1_beat,
  output logic       c2h_0_valid,
  output logic       c2h_1_valid,
  input  logic       c2h_0_ready,
  input  logic       c2h_1_ready
);

  logic      sop;
  logic      rx_fire;
  logic      dst_0;
  logic      dst_1;
  pkt_size_t size_0_q;
  pkt_size_t size_1_q;

  assign dst_0 = nf_rx_beat.tuser.dst[`QDMA0_DST_BIT];
  assign dst_1 = nf_rx_beat.tuser.dst[`QDMA1_DST_BIT];

  // a stall on either queue holds the input
  assign nf_rx_ready = c2h_0_ready && c2h_1_ready && !dp_rst;
  assign rx_fire     = nf_rx_valid && nf_rx_ready;

  // valid also waits on the other queue so a beat moves once on each queue
  assign c2h_0_valid = nf_rx_valid && dst_0 && c2h_1_ready && !dp_rst;
  assign c2h_1_valid = nf_rx_valid && dst_1 && c2h_0_ready && !dp_rst;

  // start of packet, set again after each last beat
  always_ff @(posedge axis_aclk) begin
    if (dp_rst) begin
      sop <= 1'b1;
    end else if (rx_fire) begin
      sop <= nf_rx_beat.last;
    end
  end

  // per-packet size captured from the first beat
  always_ff @(posedge axis_aclk) begin
    if (rx_fire && sop && dst_0) begin
      size_0_q <= nf_rx_beat.tuser.size;
    end
    if (rx_fire && sop && dst_1) begin
      size_1_q <= nf_rx_beat.tuser.size;
    end
  end

  always_comb begin
    c2h_0_beat.data = nf_rx_beat.data;
    c2h_0_beat.keep = nf_rx_beat.keep;
    c2h_0_beat.last = nf_rx_beat.last;
    c2h_0_beat.src  = `QTAG_W'(nf_rx_beat.tuser.src);
    c2h_0_beat.size = (sop && dst_0) ? nf_rx_beat.tuser.size : size_0_q;
    c2h_0_beat.dst  = `QDMA0_TAG;
    c2h_1_beat.data = nf_rx_beat.data;
    c2h_1_beat.keep = nf_rx_beat.keep;
    c2h_1_beat.last = nf_rx_beat.last;
    c2h_1_beat.src  = `QTAG_W'(nf_rx_beat.tuser.src);
    c2h_1_beat.size = (sop && dst_1) ? nf_rx_beat.tuser.size : size_1_q;
    c2h_1_beat.dst  = `QDMA1_TAG;
  end

endmodule

`default_nettype wire

// ==== logic/h2c_merge.sv ====
// registered mux that forwards the granted host-to-card beat to the pipeline
`timescale 1ns/100ps
`default_nettype none

`include "dma_bridge_params.svh"

module h2c_merge
  import dma_bridge_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       dp_rst,
  input  qdma_beat_t h2c_0_beat,
  input  qdma_beat_t h2c_1_beat,
  input  logic       h2c_0_fire,
  input  logic       h2c_1_fire,
  output nf_beat_t   nf_tx_beat,
  output logic       nf_tx_valid
);

  qdma_beat_t sel_beat;
  ifnum_t     sel_ifnum;

  // the grant makes the fires one-hot, queue 1 only wins when it fires
  assign sel_beat  = h2c_1_fire ? h2c_1_beat : h2c_0_beat;
  assign sel_ifnum = h2c_1_fire ? `QDMA1_IFNUM : `QDMA0_IFNUM;

  always_ff @(posedge axis_aclk) begin
    if (dp_rst) begin
      nf_tx_valid <= 1'b0;
    end else begin
      nf_tx_valid <= h2c_0_fire || h2c_1_fire;
    end
  end

  // payload of the accepted beat, tagged with its source interface
  always_ff @(posedge axis_aclk) begin
    if (h2c_0_fire || h2c_1_fire) begin
      nf_tx_beat.data           <= sel_beat.data;
      nf_tx_beat.keep           <= sel_beat.keep;
      nf_tx_beat.last           <= sel_beat.last;
      nf_tx_beat.tuser.size     <= sel_beat.size;
      nf_tx_beat.tuser.src      <= sel_ifnum;
      nf_tx_beat.tuser.dst      <= '0;
      nf_tx_beat.tuser.reserved <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/h2c_grant_fsm.sv ====
// grant state machine that gives one host-to-card queue the merge per packet
`timescale 1ns/100ps
`default_nettype none

module h2c_grant_fsm
  import dma_bridge_pkg::*;
(
  input  logic axis_aclk,
  input  logic dp_rst,
  input  logic h2c_0_valid,
  input  logic h2c_0_last,
  input  logic h2c_1_valid,
  input  logic h2c_1_last,
  output logic h2c_0_ready,
  output logic h2c_1_ready
);

  grant_state_e state;
  grant_state_e state_next;
  logic         fire_0;
  logic         fire_1;

  // idle grants in the same cycle, queue 0 has priority
  always_comb begin
    h2c_0_ready = 1'b0;
    h2c_1_ready = 1'b0;
    case (state)
      GRANT_IDLE: begin
        h2c_0_ready = h2c_0_valid;
        h2c_1_ready = !h2c_0_valid && h2c_1_valid;
      end
      GRANT_Q0: h2c_0_ready = 1'b1;
      GRANT_Q1: h2c_1_ready = 1'b1;
      default: ;
    endcase
    if (dp_rst) begin
      h2c_0_ready = 1'b0;
      h2c_1_ready = 1'b0;
    end
  end

  assign fire_0 = h2c_0_valid && h2c_0_ready;
  assign fire_1 = h2c_1_valid && h2c_1_ready;

  // grant is held until the last beat of the granted packet moves
  always_comb begin
    state_next = state;
    case (state)
      GRANT_IDLE: begin
        if (fire_0 && !h2c_0_last) begin
          state_next = GRANT_Q0;
        end else if (fire_1 && !h2c_1_last) begin
          state_next = GRANT_Q1;
        end
      end
      GRANT_Q0: if (fire_0 && h2c_0_last) state_next = GRANT_IDLE;
      GRANT_Q1: if (fire_1 && h2c_1_last) state_next = GRANT_IDLE;
      default: state_next = GRANT_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (dp_rst) begin
      state <= GRANT_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reset_hold_timer.sv ====
// reset hold timer that stretches the input reset for the datapath
`timescale 1ns/100ps
`default_nettype none

`include "dma_bridge_params.svh"

module reset_hold_timer (
  input  logic axis_aclk,
  input  logic axis_rst,
  output logic dp_rst
);

  logic [`HOLD_CNT_W-1:0] hold_cnt;
  logic                   hold_q;

  // counter is reloaded as long as the input reset is asserted
  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      hold_cnt <= `HOLD_CNT_W'(`RST_HOLD_CYCLES);
      hold_q   <= 1'b1;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
      hold_q   <= 1'b1;
    end else begin
      hold_q   <= 1'b0;
    end
  end

  // input reset reaches the datapath without waiting for an edge
  assign dp_rst = axis_rst | hold_q;

endmodule

`default_nettype wire

// ==== logic/dma_bridge_pkg.sv ====
// package with vector types, beat structs and the grant state enum
`default_nettype none

`include "dma_bridge_params.svh"

package dma_bridge_pkg;

  typedef logic [`DATA_W-1:0]  data_t;
  typedef logic [`KEEP_W-1:0]  keep_t;
  typedef logic [`SIZE_W-1:0]  pkt_size_t;
  typedef logic [`IFNUM_W-1:0] ifnum_t;
  typedef logic [`QTAG_W-1:0]  qtag_t;

  // pipeline sideband, size sits in the low bits with src and dst above it
  typedef struct packed {
    logic [7:0] reserved;
    ifnum_t     dst;
    ifnum_t     src;
    pkt_size_t  size;
  } nf_tuser_t;

  // one beat of the pipeline-side stream
  typedef struct packed {
    data_t     data;
    keep_t     keep;
    nf_tuser_t tuser;
    logic      last;
  } nf_beat_t;

  // one beat of a dma queue stream, src and dst are queue tags
  typedef struct packed {
    data_t     data;
    keep_t     keep;
    logic      last;
    pkt_size_t size;
    qtag_t     src;
    qtag_t     dst;
  } qdma_beat_t;

  typedef enum logic [1:0] {GRANT_IDLE, GRANT_Q0, GRANT_Q1} grant_state_e;

endpackage

`default_nettype wire

// ==== logic/dma_bridge_params.svh ====
// widths, interface numbers, queue tags and reset hold length for the dma bridge
`ifndef DMA_BRIDGE_PARAMS_SVH
`define DMA_BRIDGE_PARAMS_SVH

// datapath widths
`define DATA_W          64
`define KEEP_W          (`DATA_W/8)
`define SIZE_W          16
`define IFNUM_W         8
`define QTAG_W          16

// pipeline interface numbers of the two dma queues
`define QDMA0_IFNUM     8'h02
`define QDMA1_IFNUM     8'h08

// tuser dst bits that steer a packet to each card-to-host queue
`define QDMA0_DST_BIT   1
`define QDMA1_DST_BIT   3

// dst tags sent with card-to-host beats
`define QDMA0_TAG       16'h0001
`define QDMA1_TAG       16'h0002

// datapath reset outlasts the input reset by this many cycles
`define RST_HOLD_CYCLES 16
`define HOLD_CNT_W      5

`endif
